//--- src.f
+incdir+.
axi2wb_pkg.sv
axi2wb_ifs.sv
aw_burst_tracker.sv
wb_write_issuer.sv
bresp_queue.sv
axi2wb_top.sv
axi2wb_properties.sv
axi2wb_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module axi2wb_tb -f src.f -o axi2wb_sim

./obj_dir/axi2wb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1

//--- axi2wb_tb.sv
////////////////////////////////////////////////////////////
// bridge testbench with random bursts against a wishbone model
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

module axi2wb_tb;

	localparam int NUM_BURSTS  = 40;
	// four fill the b queue and the fifth waits for room
	localparam int HOLD_BURSTS = 5;
	localparam int WORD_W      = `AXI2WB_ADDR_W - `AXI2WB_LANE_W;
	// slave answers err inside this word window
	localparam int ERR_LO      = 40;
	localparam int ERR_HI      = 43;
	localparam int LIMIT       = (NUM_BURSTS + HOLD_BURSTS) * 40 + 20;

	logic                      S_AXI_ACLK;
	logic                      S_AXI_ARESETN;
	logic                      i_axi_awvalid;
	logic                      o_axi_awready;
	logic [`AXI2WB_ID_W-1:0]   i_axi_awid;
	logic [`AXI2WB_ADDR_W-1:0] i_axi_awaddr;
	logic [`AXI2WB_LEN_W-1:0]  i_axi_awlen;
	logic [1:0]                i_axi_awburst;
	logic                      i_axi_wvalid;
	logic                      o_axi_wready;
	logic [`AXI2WB_DATA_W-1:0] i_axi_wdata;
	logic [`AXI2WB_STRB_W-1:0] i_axi_wstrb;
	logic                      o_axi_bvalid;
	logic                      i_axi_bready;
	logic [`AXI2WB_ID_W-1:0]   o_axi_bid;
	logic [1:0]                o_axi_bresp;
	logic                      o_wb_cyc;
	logic                      o_wb_stb;
	logic [WORD_W-1:0]         o_wb_addr;
	logic [`AXI2WB_DATA_W-1:0] o_wb_data;
	logic [`AXI2WB_STRB_W-1:0] o_wb_sel;
	logic                      i_wb_stall;
	logic                      i_wb_ack;
	logic                      i_wb_err;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] lfsr = 32'd92381;
	// bready forced low while set
	logic        hold_b = 1'b0;
	// last burst tag that got err
	int          dead_tag = -1;
	logic        cyc_check = 1'b0;
	int          head_wait = -1;

	// expected strobes, one entry per accepted w beat
	int          exp_tag [$];
	logic [WORD_W-1:0] exp_word [$];
	logic [31:0] exp_data [$];
	logic [3:0]  exp_sel [$];
	// expected b responses in aw order
	logic [3:0]  exp_bid [$];
	logic        exp_berr [$];
	// strobes waiting for ack or err
	int          out_tag [$];
	logic        out_err [$];

	axi2wb_top dut_i (.*);

	bind axi2wb_top axi2wb_properties props_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awready     (o_axi_awready),
		.i_wb_cyc      (o_wb_cyc),
		.i_wb_stb      (o_wb_stb),
		.i_bvalid      (o_axi_bvalid),
		.i_bready      (i_axi_bready),
		.i_bid         (o_axi_bid),
		.i_bresp       (o_axi_bresp)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = !S_AXI_ACLK;
	end

	// fibonacci lfsr with taps 32 22 2 1, stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic in_window(input logic [WORD_W-1:0] w);
		return (w >= ERR_LO) && (w <= ERR_HI);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	////////////////////////////////////////////////////////////
	// one aw burst and its w beats
	////////////////////////////////////////////////////////////
	task automatic run_burst(input int tag);
		logic [7:0]        len;
		logic              incr;
		logic [3:0]        id;
		logic [WORD_W-1:0] word;
		logic [1:0]        lane;
		logic              berr;
		int                gap;
		len  = rand_bits(3);
		incr = rand_bits(1);
		id   = rand_bits(4);
		word = rand_bits(6);
		lane = rand_bits(2);
		berr = 1'b0;
		// slverr when any beat lands in the window
		for (int b = 0; b <= len; b++)
			if (in_window(word + (incr ? b : 0)))
				berr = 1'b1;
		@(negedge S_AXI_ACLK);
		i_axi_awvalid = 1'b1;
		i_axi_awid    = id;
		i_axi_awaddr  = {word, lane};
		i_axi_awlen   = len;
		i_axi_awburst = incr ? 2'b01 : 2'b00;
		do
			@(posedge S_AXI_ACLK);
		while (!o_axi_awready);
		exp_bid.push_back(id);
		exp_berr.push_back(berr);
		@(negedge S_AXI_ACLK);
		i_axi_awvalid = 1'b0;
		for (int b = 0; b <= len; b++)
		begin
			gap = rand_bits(2);
			repeat (gap) @(negedge S_AXI_ACLK);
			i_axi_wvalid = 1'b1;
			i_axi_wdata  = rand_bits(32);
			i_axi_wstrb  = rand_bits(4);
			do
				@(posedge S_AXI_ACLK);
			while (!o_axi_wready);
			exp_tag.push_back(tag);
			exp_word.push_back(word + (incr ? b : 0));
			exp_data.push_back(i_axi_wdata);
			exp_sel.push_back(i_axi_wstrb);
			@(negedge S_AXI_ACLK);
			i_axi_wvalid = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// wishbone slave model and strobe scoreboard
	////////////////////////////////////////////////////////////
	always @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
		begin
			// cycle must close right after err
			if (cyc_check)
			begin
				check_value("o_wb_cyc", o_wb_cyc, 0);
				cyc_check = 1'b0;
			end
			if (i_wb_ack || i_wb_err)
			begin
				if (out_tag.size() == 0)
					note_failure("wishbone answer sent with no strobe outstanding");
				else if (i_wb_err)
				begin
					dead_tag = out_tag[0];
					out_tag.delete();
					out_err.delete();
					cyc_check = 1'b1;
				end
				else
				begin
					void'(out_tag.pop_front());
					void'(out_err.pop_front());
				end
			end
			// strobe taken by the slave
			if (o_wb_cyc && o_wb_stb && !i_wb_stall && !i_wb_err)
			begin
				while (exp_tag.size() > 0 && exp_tag[0] <= dead_tag)
				begin
					void'(exp_tag.pop_front());
					void'(exp_word.pop_front());
					void'(exp_data.pop_front());
					void'(exp_sel.pop_front());
				end
				if (exp_tag.size() == 0)
					note_failure("wishbone strobe with no write beat behind it");
				else
				begin
					check_value("o_wb_addr", o_wb_addr, exp_word.pop_front());
					check_value("o_wb_data", o_wb_data, exp_data.pop_front());
					check_value("o_wb_sel", o_wb_sel, exp_sel.pop_front());
					out_tag.push_back(exp_tag.pop_front());
					out_err.push_back(in_window(o_wb_addr));
				end
			end
			// b channel against aw order
			if (o_axi_bvalid && i_axi_bready)
			begin
				if (exp_bid.size() == 0)
					note_failure("b response with no burst outstanding");
				else
				begin
					check_value("o_axi_bid", o_axi_bid, exp_bid.pop_front());
					check_value("o_axi_bresp", o_axi_bresp,
						exp_berr.pop_front() ? 2'b10 : 2'b00);
				end
			end
		end
	end

	// stall, ack delay 0 to 3 and bready
	always @(negedge S_AXI_ACLK)
	begin
		i_wb_stall   = (rand_bits(2) == 0);
		i_wb_ack     = 1'b0;
		i_wb_err     = 1'b0;
		i_axi_bready = hold_b ? 1'b0 : (rand_bits(2) != 0);
		if (out_tag.size() > 0)
		begin
			if (head_wait < 0)
				head_wait = rand_bits(2);
			if (head_wait == 0)
			begin
				if (out_err[0])
					i_wb_err = 1'b1;
				else
					i_wb_ack = 1'b1;
				head_wait = -1;
			end
			else
				head_wait--;
		end
	end

	// watchdog
	initial
	begin
		repeat (LIMIT) @(posedge S_AXI_ACLK);
		$display("timeout, the bursts did not complete in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		S_AXI_ARESETN = 1'b0;
		i_axi_awvalid = 1'b0;
		i_axi_awid    = '0;
		i_axi_awaddr  = '0;
		i_axi_awlen   = '0;
		i_axi_awburst = '0;
		i_axi_wvalid  = 1'b0;
		i_axi_wdata   = '0;
		i_axi_wstrb   = '0;
		i_axi_bready  = 1'b0;
		i_wb_stall    = 1'b0;
		i_wb_ack      = 1'b0;
		i_wb_err      = 1'b0;
		repeat (5) @(posedge S_AXI_ACLK);
		check_value("o_axi_awready", o_axi_awready, 0);
		check_value("o_axi_wready", o_axi_wready, 0);
		check_value("o_wb_cyc", o_wb_cyc, 0);
		check_value("o_wb_stb", o_wb_stb, 0);
		check_value("o_axi_bvalid", o_axi_bvalid, 0);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		// release cycle still shows awready low
		@(posedge S_AXI_ACLK);
		check_value("o_axi_awready", o_axi_awready, 0);
		@(posedge S_AXI_ACLK);
		check_value("o_axi_awready", o_axi_awready, 1);

		for (int t = 0; t < NUM_BURSTS; t++)
			run_burst(t);

		// drain the b queue and then fill it with bready low
		while (exp_bid.size() > 0)
			@(posedge S_AXI_ACLK);
		hold_b = 1'b1;
		for (int t = 0; t < HOLD_BURSTS - 1; t++)
			run_burst(NUM_BURSTS + t);
		@(posedge S_AXI_ACLK);
		while (o_wb_cyc)
			@(posedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		repeat (16)
		begin
			@(posedge S_AXI_ACLK);
			check_value("o_axi_awready", o_axi_awready, 0);
		end
		hold_b = 1'b0;
		run_burst(NUM_BURSTS + HOLD_BURSTS - 1);

		while (exp_bid.size() > 0)
			@(posedge S_AXI_ACLK);
		while (exp_tag.size() > 0 && exp_tag[0] <= dead_tag)
			void'(exp_tag.pop_front());
		check_value("strobes missing", exp_tag.size(), 0);
		check_value("acks missing", out_tag.size(), 0);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- axi2wb_properties.sv
////////////////////////////////////////////////////////////
// bridge port properties, bound onto the top level
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

module axi2wb_properties (
	input logic                    S_AXI_ACLK,
	input logic                    S_AXI_ARESETN,
	input logic                    i_awready,
	input logic                    i_wb_cyc,
	input logic                    i_wb_stb,
	input logic                    i_bvalid,
	input logic                    i_bready,
	input logic [`AXI2WB_ID_W-1:0] i_bid,
	input logic [1:0]              i_bresp
);

	// a strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_wb_stb |-> i_wb_cyc)
		else $error("wishbone strobe outside a cycle");

	// okay or slverr only
	bresp_legal: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_bvalid |-> (i_bresp == 2'b00 || i_bresp == 2'b10))
		else $error("b response code out of range");

	// one burst at a time on wishbone
	aw_closed_in_cyc: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$rose(i_awready) |-> !i_wb_cyc)
		else $error("awready rose during a wishbone cycle");

	// b channel holds until taken
	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_bvalid && !i_bready) |=> (i_bvalid && $stable(i_bid) && $stable(i_bresp)))
		else $error("b channel changed before bready");

endmodule

//--- axi2wb_top.sv
////////////////////////////////////////////////////////////
// axi4 write slave to wishbone pipelined write bridge
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

module axi2wb_top (
	input  logic                                    S_AXI_ACLK,
	input  logic                                    S_AXI_ARESETN,
	// aw channel
	input  logic                                    i_axi_awvalid,
	output logic                                    o_axi_awready,
	input  logic [`AXI2WB_ID_W-1:0]                 i_axi_awid,
	input  logic [`AXI2WB_ADDR_W-1:0]               i_axi_awaddr,
	input  logic [`AXI2WB_LEN_W-1:0]                i_axi_awlen,
	input  logic [1:0]                              i_axi_awburst,
	// w channel
	input  logic                                    i_axi_wvalid,
	output logic                                    o_axi_wready,
	input  logic [`AXI2WB_DATA_W-1:0]               i_axi_wdata,
	input  logic [`AXI2WB_STRB_W-1:0]               i_axi_wstrb,
	// b channel
	output logic                                    o_axi_bvalid,
	input  logic                                    i_axi_bready,
	output logic [`AXI2WB_ID_W-1:0]                 o_axi_bid,
	output logic [1:0]                              o_axi_bresp,
	// wishbone master
	output logic                                    o_wb_cyc,
	output logic                                    o_wb_stb,
	output logic [`AXI2WB_ADDR_W-`AXI2WB_LANE_W-1:0] o_wb_addr,
	output logic [`AXI2WB_DATA_W-1:0]               o_wb_data,
	output logic [`AXI2WB_STRB_W-1:0]               o_wb_sel,
	input  logic                                    i_wb_stall,
	input  logic                                    i_wb_ack,
	input  logic                                    i_wb_err
);

	// held awid, tracker to issuer
	logic [`AXI2WB_ID_W-1:0] burst_id;
	// burst finished on wishbone
	logic                    burst_done;

	beat_if beat_i ();
	resp_if resp_i ();

	////////////////////////////////////////////////////////////
	// aw/w in, single beats out
	////////////////////////////////////////////////////////////
	aw_burst_tracker tracker_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awvalid     (i_axi_awvalid),
		.o_awready     (o_axi_awready),
		.i_awid        (i_axi_awid),
		.i_awaddr      (i_axi_awaddr),
		.i_awlen       (i_axi_awlen),
		.i_awburst     (i_axi_awburst),
		.i_wvalid      (i_axi_wvalid),
		.o_wready      (o_axi_wready),
		.i_wdata       (i_axi_wdata),
		.i_wstrb       (i_axi_wstrb),
		.i_resp_full   (resp_i.full),
		.i_done        (burst_done),
		.o_id          (burst_id),
		.beat          (beat_i.src)
	);

	// beats onto wishbone, one response per burst
	wb_write_issuer issuer_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_wb_stall    (i_wb_stall),
		.i_wb_ack      (i_wb_ack),
		.i_wb_err      (i_wb_err),
		.i_id          (burst_id),
		.o_wb_cyc      (o_wb_cyc),
		.o_wb_stb      (o_wb_stb),
		.o_wb_addr     (o_wb_addr),
		.o_wb_data     (o_wb_data),
		.o_wb_sel      (o_wb_sel),
		.o_done        (burst_done),
		.beat          (beat_i.snk),
		.resp          (resp_i.src)
	);

	// responses queued for the b channel
	bresp_queue bresp_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_bready      (i_axi_bready),
		.o_bvalid      (o_axi_bvalid),
		.o_bid         (o_axi_bid),
		.o_bresp       (o_axi_bresp),
		.resp          (resp_i.snk)
	);

endmodule

//--- bresp_queue.sv
////////////////////////////////////////////////////////////
// b response fifo, one entry per finished burst
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

module bresp_queue (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	input  logic                    i_bready,
	output logic                    o_bvalid,
	output logic [`AXI2WB_ID_W-1:0] o_bid,
	output logic [1:0]              o_bresp,
	resp_if.snk                     resp
);

	localparam int DEPTH = 1 << `AXI2WB_RESP_DEPTH_LG;

	logic [`AXI2WB_ID_W-1:0]         id_mem [DEPTH];
	logic                            err_mem [DEPTH];
	logic [`AXI2WB_RESP_DEPTH_LG-1:0] wr_ptr;
	logic [`AXI2WB_RESP_DEPTH_LG-1:0] rd_ptr;
	// one extra bit, top bit set means full
	logic [`AXI2WB_RESP_DEPTH_LG:0]   fill;
	logic                            push_ok;
	logic                            pop;

	assign resp.full = fill[`AXI2WB_RESP_DEPTH_LG];
	assign push_ok   = resp.push && !resp.full;
	assign pop       = o_bvalid && i_bready;

	// head entry is the b channel
	assign o_bvalid = (fill != '0);
	assign o_bid    = id_mem[rd_ptr];
	// slverr or okay
	assign o_bresp  = err_mem[rd_ptr] ? 2'b10 : 2'b00;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (push_ok)
		begin
			id_mem[wr_ptr]  <= resp.id;
			err_mem[wr_ptr] <= resp.err;
		end
	end

	// pointers wrap on their own width
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

endmodule

//--- wb_write_issuer.sv
////////////////////////////////////////////////////////////
// wishbone pipelined write master, one burst at a time
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

module wb_write_issuer (
	input  logic                                    S_AXI_ACLK,
	input  logic                                    S_AXI_ARESETN,
	input  logic                                    i_wb_stall,
	input  logic                                    i_wb_ack,
	input  logic                                    i_wb_err,
	input  logic [`AXI2WB_ID_W-1:0]                 i_id,
	output logic                                    o_wb_cyc,
	output logic                                    o_wb_stb,
	output logic [`AXI2WB_ADDR_W-`AXI2WB_LANE_W-1:0] o_wb_addr,
	output logic [`AXI2WB_DATA_W-1:0]               o_wb_data,
	output logic [`AXI2WB_STRB_W-1:0]               o_wb_sel,
	output logic                                    o_done,
	beat_if.snk                                     beat,
	resp_if.src                                     resp
);

	logic                     accept;
	logic                     issue;
	// sticky after err, beats dropped up to last
	logic                     err_mode;
	logic                     last_seen;
	// strobes issued and not yet answered
	logic [`AXI2WB_LEN_W:0]   pending;
	logic                     bus_err;
	logic                     final_ack;
	logic                     finish;
	logic                     resp_err;

	// stalled strobe holds the beat back
	assign beat.ready = !(o_wb_stb && i_wb_stall);
	assign accept     = beat.valid && beat.ready;
	// only a live burst issues strobes
	assign issue      = accept && !err_mode;

	assign bus_err   = o_wb_cyc && i_wb_err;
	assign final_ack = o_wb_cyc && i_wb_ack && !i_wb_err && last_seen && (pending == 1);

	// clean end, err after last, or end of the discard
	assign finish = final_ack
		|| (bus_err && (last_seen || (accept && beat.last)))
		|| (err_mode && accept && beat.last);

	////////////////////////////////////////////////////////////
	// bus control
	////////////////////////////////////////////////////////////

	// cyc comes up with the first strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else if (bus_err || final_ack)
		begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else if (issue)
		begin
			o_wb_cyc <= 1'b1;
			o_wb_stb <= 1'b1;
		end
		else if (!i_wb_stall)
			o_wb_stb <= 1'b0;
	end

	// beat payload onto the bus
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (issue)
		begin
			o_wb_addr <= beat.addr.split.word_idx;
			o_wb_data <= beat.data;
			o_wb_sel  <= beat.sel;
		end
	end

	////////////////////////////////////////////////////////////
	// ack and err accounting
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || bus_err || final_ack)
			pending <= '0;
		else
		begin
			case ({issue, o_wb_cyc && i_wb_ack})
				2'b10:   pending <= pending + 1'b1;
				2'b01:   pending <= pending - 1'b1;
				default: pending <= pending;
			endcase
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || finish)
		begin
			err_mode  <= 1'b0;
			last_seen <= 1'b0;
		end
		else
		begin
			if (bus_err)
				err_mode <= 1'b1;
			if (accept && beat.last)
				last_seen <= 1'b1;
		end
	end

	// done and the response push share the cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_done <= 1'b0;
		else
			o_done <= finish;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (finish)
			resp_err <= err_mode || bus_err;
	end

	assign resp.push = o_done;
	assign resp.id   = i_id;
	assign resp.err  = resp_err;

endmodule

//--- aw_burst_tracker.sv
////////////////////////////////////////////////////////////
// accepts aw and w and unwinds one burst into single beats
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

module aw_burst_tracker (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_awvalid,
	output logic                      o_awready,
	input  logic [`AXI2WB_ID_W-1:0]   i_awid,
	input  axi2wb_pkg::addr_u         i_awaddr,
	input  logic [`AXI2WB_LEN_W-1:0]  i_awlen,
	input  logic [1:0]                i_awburst,
	input  logic                      i_wvalid,
	output logic                      o_wready,
	input  logic [`AXI2WB_DATA_W-1:0] i_wdata,
	input  logic [`AXI2WB_STRB_W-1:0] i_wstrb,
	input  logic                      i_resp_full,
	input  logic                      i_done,
	output logic [`AXI2WB_ID_W-1:0]   o_id,
	beat_if.src                       beat
);

	// address step for incr
	localparam logic [`AXI2WB_ADDR_W-1:0] BYTES_PER_WORD = `AXI2WB_STRB_W;

	// set from the first edge out of reset
	logic                            live;
	// burst owns the bridge until the issuer reports done
	logic                            busy;
	// beats of the burst still to come
	logic                            w_open;
	logic [`AXI2WB_ID_W-1:0]         burst_id;
	axi2wb_pkg::addr_u               burst_addr;
	axi2wb_pkg::burst_kind_e         burst_kind;
	// counts down to zero on the last beat
	logic [`AXI2WB_LEN_W-1:0]        beats_left;
	logic                            aw_accept;
	logic                            w_accept;

	////////////////////////////////////////////////////////////
	// handshakes
	////////////////////////////////////////////////////////////

	// no new burst until out of reset, while one is open
	// or while its response has no room
	assign o_awready = live && !busy && !i_resp_full;
	assign aw_accept = i_awvalid && o_awready;

	// w passes straight through and the issuer registers it
	assign beat.valid = w_open && i_wvalid;
	assign o_wready   = w_open && beat.ready;
	assign w_accept   = beat.valid && beat.ready;

	assign beat.addr = burst_addr;
	assign beat.data = i_wdata;
	assign beat.sel  = i_wstrb;
	assign beat.last = (beats_left == '0);

	// held for the response push
	assign o_id = burst_id;

	// awready stays low through the release cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			live <= 1'b0;
		else
			live <= 1'b1;
	end

	// busy and w_open
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			busy   <= 1'b0;
			w_open <= 1'b0;
		end
		else if (aw_accept)
		begin
			busy   <= 1'b1;
			w_open <= 1'b1;
		end
		else if (i_done)
		begin
			busy   <= 1'b0;
			w_open <= 1'b0;
		end
		else if (w_accept && beat.last)
			w_open <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// burst state
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_accept)
		begin
			burst_id   <= i_awid;
			burst_addr <= i_awaddr;
			burst_kind <= (i_awburst == 2'b00) ? axi2wb_pkg::BURST_FIXED
				: axi2wb_pkg::BURST_INCR;
			beats_left <= i_awlen;
		end
		else if (w_accept)
		begin
			if (!beat.last)
				beats_left <= beats_left - 1'b1;
			// fixed keeps the start address
			if (burst_kind == axi2wb_pkg::BURST_INCR)
				burst_addr.byte_addr <= burst_addr.byte_addr + BYTES_PER_WORD;
		end
	end

endmodule

//--- axi2wb_ifs.sv
////////////////////////////////////////////////////////////
// beat and response links between the bridge blocks
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

////////////////////////////////////////////////////////////
// one write beat, tracker to issuer
////////////////////////////////////////////////////////////
interface beat_if;

	// transfers when valid and ready are both high
	logic                      valid;
	logic                      ready;
	axi2wb_pkg::addr_u         addr;
	logic [`AXI2WB_DATA_W-1:0] data;
	logic [`AXI2WB_STRB_W-1:0] sel;
	// final beat of the burst
	logic                      last;

	// tracker side
	modport src (output valid, addr, data, sel, last, input ready);

	// issuer side
	modport snk (input valid, addr, data, sel, last, output ready);

endinterface

////////////////////////////////////////////////////////////
// one burst response, issuer to b queue
////////////////////////////////////////////////////////////
interface resp_if;

	// single cycle, one per burst
	logic                    push;
	logic [`AXI2WB_ID_W-1:0] id;
	// any beat of the burst saw err
	logic                    err;
	// queue has no free entry
	logic                    full;

	modport src (output push, id, err);

	modport snk (input push, id, err, output full);

endinterface

//--- axi2wb_pkg.sv
////////////////////////////////////////////////////////////
// axi4 write to wishbone bridge, shared types
////////////////////////////////////////////////////////////
`include "axi2wb_settings.svh"

package axi2wb_pkg;

	// word index plus byte lane
	typedef struct packed
	{
		logic [`AXI2WB_ADDR_W-`AXI2WB_LANE_W-1:0] word_idx;
		logic [`AXI2WB_LANE_W-1:0]                lane;
	} addr_split_t;

	// one address word, two views
	// byte view for stepping, split view for the wishbone address
	typedef union packed
	{
		logic [`AXI2WB_ADDR_W-1:0] byte_addr;
		addr_split_t               split;
	} addr_u;

	// awburst code 0 is fixed, wrap folds into incr
	typedef enum logic
	{
		BURST_FIXED = 1'b0,
		BURST_INCR  = 1'b1
	} burst_kind_e;

endpackage

//--- axi2wb_settings.svh
////////////////////////////////////////////////////////////
// axi4 write to wishbone bridge, shared widths and depths
////////////////////////////////////////////////////////////
`ifndef AXI2WB_SETTINGS_SVH
`define AXI2WB_SETTINGS_SVH

// axi id width
`define AXI2WB_ID_W 4

// axi byte address width
`define AXI2WB_ADDR_W 16

// data bus width, same on both sides
`define AXI2WB_DATA_W 32

// byte lane bits, log2 of bytes per word
`define AXI2WB_LANE_W 2

// one strobe bit per byte
`define AXI2WB_STRB_W 4

// awlen width
`define AXI2WB_LEN_W 8

// log2 of the b response queue depth
`define AXI2WB_RESP_DEPTH_LG 2

`endif
